// File: Bender.yml
package:
  name: stage_engine

sources:
  - include_dirs:
      - src
    files:
      - src/stage_pkg.sv
      - src/stage_if.sv
      - src/stage_decode.sv
      - src/lane_execute.sv
      - src/lane_accumulate.sv
      - src/stage_engine_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clock.sv
      - sim/tb_stage_engine.sv

// File: list.f
+incdir+src
src/stage_pkg.sv
src/stage_if.sv
src/stage_decode.sv
src/lane_execute.sv
src/lane_accumulate.sv
src/stage_engine_top.sv
sim/tb_clock.sv
sim/tb_stage_engine.sv

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int RESET_CYCLES = 16
) (
  input  logic restart_i,
  output logic clk_o,
  output logic rst_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset at start and again on every restart request
  initial begin
    rst_o = 1'b1;
    forever begin
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2;
      rst_o = 1'b0;
      @(posedge restart_i);
      rst_o = 1'b1;  // Same 2 ns offset as the request
    end
  end

endmodule

// File: sim/tb_stage_engine.sv
`timescale 1ns/1ns
`include "stage_defs.svh"

module tb_stage_engine;

  localparam int RESET_CYCLES = 16;
  localparam int HOLD_CYCLES  = 20;
  localparam int PIPE_DEPTH   = 3;  // Step inputs reach acc_o after three edges

  // Nondecreasing tables where B and C repeat boundaries to skip stages
  localparam stage_pkg::step_t [`STAGE_BOUNDS-1:0] TABLE_A =
    {16'd32, 16'd28, 16'd24, 16'd20, 16'd16, 16'd12, 16'd8, 16'd4};
  localparam stage_pkg::step_t [`STAGE_BOUNDS-1:0] TABLE_B =
    {16'd26, 16'd20, 16'd15, 16'd15, 16'd12, 16'd7, 16'd7, 16'd3};
  localparam stage_pkg::step_t [`STAGE_BOUNDS-1:0] TABLE_C =
    {16'd30, 16'd27, 16'd22, 16'd22, 16'd14, 16'd10, 16'd6, 16'd5};

  localparam int STEP_TOTAL = TABLE_A[`STAGE_BOUNDS-1] + TABLE_B[`STAGE_BOUNDS-1]
                            + TABLE_C[`STAGE_BOUNDS-1]
                            + 3 * (RESET_CYCLES + PIPE_DEPTH + HOLD_CYCLES + 2);
  localparam int WATCHDOG_NS = (STEP_TOTAL + 100) * 20;

  typedef struct packed {
    stage_pkg::lane_data_t acc;
    stage_pkg::stage_t     stage;
    logic                  fin;
  } expect_t;

  logic                                 clk;
  logic                                 rst;
  logic                                 restart;
  stage_pkg::step_t [`STAGE_BOUNDS-1:0] stage_boundary;
  stage_pkg::lane_data_t                operand1;
  stage_pkg::lane_data_t                operand2;
  stage_pkg::lane_data_t                operand3;
  stage_pkg::lane_data_t                operand4;
  stage_pkg::lane_data_t                set_val;
  stage_pkg::lane_data_t                acc;
  stage_pkg::stage_t                    stage;
  logic                                 finished;

  integer  seed = 32'hebc15e18;
  int      error_count = 0;
  expect_t expect_q[$];  // One entry per cycle popped at the falling edge

  tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (
    .restart_i (restart),
    .clk_o     (clk),
    .rst_o     (rst)
  );

  stage_engine_top stage_engine_top_i (
    .clk_i            (clk),
    .rst_i            (rst),
    .stage_boundary_i (stage_boundary),
    .operand1_i       (operand1),
    .operand2_i       (operand2),
    .operand3_i       (operand3),
    .operand4_i       (operand4),
    .set_i            (set_val),
    .acc_o            (acc),
    .stage_o          (stage),
    .finished_o       (finished)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic stage_pkg::data_t clamp16(input int x);
    if (x > 32767) return 16'sh7fff;
    if (x < -32768) return 16'sh8000;
    return stage_pkg::data_t'(x);
  endfunction

  // Q8.8 times Q8.8 back to Q8.8
  function automatic stage_pkg::data_t q88_product(input stage_pkg::data_t a,
                                                   input stage_pkg::data_t b);
    int full;
    full = int'(a) * int'(b);
    return clamp16(full >>> `STAGE_FRAC_W);
  endfunction

  // Count of boundaries the step has reached
  function automatic stage_pkg::stage_t stage_of_step(
    input stage_pkg::step_t                     s,
    input stage_pkg::step_t [`STAGE_BOUNDS-1:0] b
  );
    int n;
    n = 0;
    for (int i = 0; i < `STAGE_BOUNDS; i++) begin
      if (s >= b[i]) n++;
    end
    return stage_pkg::stage_t'(n);
  endfunction

  function automatic stage_pkg::op_e op_for_stage(input stage_pkg::stage_t st);
    case (st)
      4'd0, 4'd4: return stage_pkg::OP_LOAD;
      4'd1, 4'd5: return stage_pkg::OP_MAC;
      4'd2, 4'd7: return stage_pkg::OP_CORR;
      4'd3, 4'd6: return stage_pkg::OP_SUM;
      default:    return stage_pkg::OP_HOLD;
    endcase
  endfunction

  // Expected accumulators after one step
  function automatic stage_pkg::lane_data_t apply_step(
    input stage_pkg::lane_data_t acc_in,
    input stage_pkg::op_e        op,
    input stage_pkg::lane_data_t op1,
    input stage_pkg::lane_data_t op2,
    input stage_pkg::lane_data_t op3,
    input stage_pkg::lane_data_t op4,
    input stage_pkg::lane_data_t set_in
  );
    stage_pkg::lane_data_t r;
    stage_pkg::data_t      a;
    stage_pkg::data_t      x1;
    stage_pkg::data_t      x3;
    stage_pkg::data_t      x4;
    stage_pkg::data_t      p;
    stage_pkg::data_t      corr;
    for (int i = 0; i < `STAGE_LANES; i++) begin
      a  = acc_in[i];
      x1 = op1[i];
      x3 = op3[i];
      x4 = op4[i];
      p  = q88_product(op2[i], op3[i]);
      case (op)
        stage_pkg::OP_LOAD: r[i] = set_in[i];
        stage_pkg::OP_MAC:  r[i] = clamp16(int'(a) + int'(p));
        stage_pkg::OP_CORR: begin
          corr = clamp16(int'(x1) + int'(x4) - int'(p));
          r[i] = clamp16(int'(a) + int'(corr));
        end
        stage_pkg::OP_SUM:  r[i] = clamp16(int'(a) + int'(x3));
        default:            r[i] = a;
      endcase
    end
    return r;
  endfunction

  // Mid range about +-2.0 and near limit about +-127
  function automatic stage_pkg::data_t rand_word(input bit near_limit);
    int mag;
    if (!near_limit) begin
      return stage_pkg::data_t'($random(seed) % 512);
    end
    mag = 32'h7e00 + ($random(seed) & 32'h1ff);
    if ($random(seed) & 1) begin
      mag = -mag;
    end
    return stage_pkg::data_t'(mag);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s expected %0h, actual %0h",
               $time, name, expected, actual);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Reset request and check of the cleared outputs
  task automatic restart_engine();
    @(posedge clk);
    #2;
    restart = 1'b1;
    @(posedge clk);
    #2;
    restart = 1'b0;
    @(negedge clk);
    for (int i = 0; i < `STAGE_LANES; i++) begin
      check_value($sformatf("acc_o[%0d]", i), '0, 32'(acc[i]));
    end
    check_value("finished_o", '0, finished);
  endtask

  task automatic run_engine(input stage_pkg::step_t [`STAGE_BOUNDS-1:0] bounds,
                            input bit near_limit);
    stage_pkg::lane_data_t acc_hist[$];
    stage_pkg::lane_data_t model;
    stage_pkg::step_t      last;
    stage_pkg::step_t      step;
    stage_pkg::stage_t     st;
    expect_t               e;
    int                    n_cycles;
    last     = bounds[`STAGE_BOUNDS-1];
    n_cycles = last + PIPE_DEPTH + HOLD_CYCLES;
    model    = '0;
    stage_boundary = bounds;  // Loaded while reset is high
    @(negedge rst);
    for (int c = 0; c < n_cycles; c++) begin
      if (c > 0) begin
        @(posedge clk);
        #2;
      end
      for (int i = 0; i < `STAGE_LANES; i++) begin
        operand1[i] = rand_word(near_limit);
        operand2[i] = rand_word(near_limit);
        operand3[i] = rand_word(near_limit);
        operand4[i] = rand_word(near_limit);
        set_val[i]  = rand_word(near_limit);
      end
      step = (c < last) ? stage_pkg::step_t'(c) : last;  // Counter parks on last
      st   = stage_of_step(step, bounds);
      if (st != stage_pkg::stage_t'(`STAGE_BOUNDS)) begin
        model = apply_step(model, op_for_stage(st), operand1, operand2, operand3,
                           operand4, set_val);
      end
      acc_hist.push_back(model);
      e.acc   = (c < PIPE_DEPTH) ? '0 : acc_hist[c - PIPE_DEPTH];
      e.stage = st;
      e.fin   = (c >= last + PIPE_DEPTH);
      expect_q.push_back(e);
    end
  endtask

  // Compare at the falling edge away from input changes
  always @(negedge clk) begin : compare
    expect_t e;
    if (expect_q.size() > 0) begin
      e = expect_q.pop_front();
      for (int i = 0; i < `STAGE_LANES; i++) begin
        check_value($sformatf("acc_o[%0d]", i), 32'(e.acc[i]), 32'(acc[i]));
      end
      check_value("stage_o", 32'(e.stage), 32'(stage));
      check_value("finished_o", 32'(e.fin), 32'(finished));
    end
  end

  initial begin
    restart        = 1'b0;
    stage_boundary = '0;
    operand1       = '0;
    operand2       = '0;
    operand3       = '0;
    operand4       = '0;
    set_val        = '0;
    run_engine(TABLE_A, 1'b0);
    restart_engine();
    run_engine(TABLE_B, 1'b1);  // Saturation run
    restart_engine();
    run_engine(TABLE_C, 1'b0);
    @(negedge clk);
    #1;
    if (expect_q.size() != 0) begin
      error_count++;
      $display("Compare process left %0d expected entries unchecked", expect_q.size());
    end
    $display("Checks done, error count %0d", error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run timed out", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: src/lane_accumulate.sv
`timescale 1ns/1ns
`include "stage_defs.svh"

module lane_accumulate (
  input  logic                  clk_i,
  input  logic                  rst_i,
  res_if.res_mp                 res,
  output stage_pkg::lane_data_t acc_o,
  output logic                  finished_o
);

  stage_pkg::lane_data_t acc_q;
  logic                  valid_q;  // res.valid one cycle late

  for (genvar i = 0; i < `STAGE_LANES; i++) begin : g_lane
    stage_pkg::data_t acc;
    stage_pkg::data_t prod;
    stage_pkg::data_t addend;

    assign acc    = acc_q[i];
    assign prod   = res.prod[i];
    assign addend = res.addend[i];

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        acc_q[i] <= '0;
      end else if (res.valid) begin
        case (res.op)
          stage_pkg::OP_LOAD: acc_q[i] <= addend;
          stage_pkg::OP_MAC:
            acc_q[i] <= stage_pkg::sat(stage_pkg::wide_t'(acc) + stage_pkg::wide_t'(prod));
          stage_pkg::OP_CORR,
          stage_pkg::OP_SUM:
            acc_q[i] <= stage_pkg::sat(stage_pkg::wide_t'(acc) + stage_pkg::wide_t'(addend));
          default:            acc_q[i] <= acc;  // Hold
        endcase
      end
    end
  end

  assign acc_o = acc_q;

  // Sticky done on the falling edge of valid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q    <= 1'b0;
      finished_o <= 1'b0;
    end else begin
      valid_q <= res.valid;
      if (valid_q && !res.valid) finished_o <= 1'b1;
    end
  end

  // No result may arrive once the run has finished
  a_finished_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    finished_o |-> !res.valid);

endmodule

// File: src/lane_execute.sv
`timescale 1ns/1ns
`include "stage_defs.svh"

module lane_execute (
  input  logic  clk_i,
  input  logic  rst_i,
  exe_if.exe_mp exe,
  res_if.exe_mp res
);

  stage_pkg::lane_data_t prod;
  stage_pkg::lane_data_t addend;

  //////////////////////////////
  // Per lane datapath
  //////////////////////////////

  for (genvar i = 0; i < `STAGE_LANES; i++) begin : g_lane
    stage_pkg::data_t a1;
    stage_pkg::data_t a2;
    stage_pkg::data_t a3;
    stage_pkg::data_t a4;
    stage_pkg::wide_t full;
    stage_pkg::data_t corr;

    // Signed views of the lane operands
    assign a1 = exe.op1[i];
    assign a2 = exe.op2[i];
    assign a3 = exe.op3[i];
    assign a4 = exe.op4[i];

    // Q16.16 product back to Q8.8
    assign full    = stage_pkg::wide_t'(a2) * stage_pkg::wide_t'(a3);
    assign prod[i] = stage_pkg::sat(full >>> `STAGE_FRAC_W);

    assign corr = stage_pkg::sat(stage_pkg::wide_t'(a1) + stage_pkg::wide_t'(a4)
                                 - stage_pkg::wide_t'(prod[i]));

    always_comb begin
      case (exe.op)
        stage_pkg::OP_LOAD: addend[i] = exe.set[i];
        stage_pkg::OP_CORR: addend[i] = corr;
        stage_pkg::OP_SUM:  addend[i] = a3;
        stage_pkg::OP_MAC:  addend[i] = prod[i];  // Accumulate takes prod anyway
        default:            addend[i] = '0;
      endcase
    end
  end

  //////////////////////////////
  // Result register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res.valid <= 1'b0;
      res.op    <= stage_pkg::OP_HOLD;
    end else begin
      res.valid <= exe.valid;
      res.op    <= exe.op;
    end
  end

  always_ff @(posedge clk_i) begin
    res.prod   <= prod;
    res.addend <= addend;
  end

  // Decode only issues hold once the table is exhausted
  a_no_hold_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    exe.valid |-> exe.op != stage_pkg::OP_HOLD);

endmodule

// File: src/stage_decode.sv
`timescale 1ns/1ns
`include "stage_defs.svh"

module stage_decode (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  stage_pkg::step_t [`STAGE_BOUNDS-1:0]     stage_boundary_i,
  input  stage_pkg::lane_data_t                    operand1_i,
  input  stage_pkg::lane_data_t                    operand2_i,
  input  stage_pkg::lane_data_t                    operand3_i,
  input  stage_pkg::lane_data_t                    operand4_i,
  input  stage_pkg::lane_data_t                    set_i,
  output stage_pkg::stage_t                        stage_o,
  exe_if.dec_mp                                    exe
);

  stage_pkg::step_t  step;
  stage_pkg::stage_t stage;
  stage_pkg::op_e    op;

  // Free running step that parks on the last boundary
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      step <= '0;
    end else if (step < stage_boundary_i[`STAGE_BOUNDS-1]) begin
      step <= step + 1'b1;
    end
  end

  // Lowest boundary still above the step wins
  always_comb begin
    stage = stage_pkg::stage_t'(`STAGE_BOUNDS);
    for (int i = `STAGE_BOUNDS - 1; i >= 0; i--) begin
      if (step < stage_boundary_i[i]) stage = stage_pkg::stage_t'(i);
    end
  end

  always_comb begin
    case (stage)
      4'd0:    op = stage_pkg::OP_LOAD;
      4'd1:    op = stage_pkg::OP_MAC;
      4'd2:    op = stage_pkg::OP_CORR;
      4'd3:    op = stage_pkg::OP_SUM;
      4'd4:    op = stage_pkg::OP_LOAD;
      4'd5:    op = stage_pkg::OP_MAC;
      4'd6:    op = stage_pkg::OP_SUM;
      4'd7:    op = stage_pkg::OP_CORR;
      default: op = stage_pkg::OP_HOLD;  // Finished
    endcase
  end

  assign stage_o = stage;

  //////////////////////////////
  // Snapshot for execute
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exe.valid <= 1'b0;
      exe.op    <= stage_pkg::OP_HOLD;
    end else begin
      exe.valid <= (stage != stage_pkg::stage_t'(`STAGE_BOUNDS));
      exe.op    <= op;
    end
  end

  always_ff @(posedge clk_i) begin
    exe.op1 <= operand1_i;
    exe.op2 <= operand2_i;
    exe.op3 <= operand3_i;
    exe.op4 <= operand4_i;
    exe.set <= set_i;
  end

  a_stage_monotonic: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> stage >= $past(stage));

  // Step at the table end means no further valid step
  a_done_no_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    step >= stage_boundary_i[`STAGE_BOUNDS-1] |=> !exe.valid);

endmodule

// File: src/stage_defs.svh
`ifndef STAGE_DEFS_SVH
`define STAGE_DEFS_SVH

//////////////////////////////
// Engine dimensions
//////////////////////////////

// Parallel lanes
`define STAGE_LANES 3

// Signed Q8.8 word
`define STAGE_DATA_W 16
`define STAGE_FRAC_W 8

// Step counter and boundary table
`define STAGE_STEP_W 16
`define STAGE_BOUNDS 8

`endif

// File: src/stage_engine_top.sv
`timescale 1ns/1ns
`include "stage_defs.svh"

module stage_engine_top (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  stage_pkg::step_t [`STAGE_BOUNDS-1:0] stage_boundary_i,
  input  stage_pkg::lane_data_t                operand1_i,
  input  stage_pkg::lane_data_t                operand2_i,
  input  stage_pkg::lane_data_t                operand3_i,
  input  stage_pkg::lane_data_t                operand4_i,
  input  stage_pkg::lane_data_t                set_i,
  output stage_pkg::lane_data_t                acc_o,
  output stage_pkg::stage_t                    stage_o,
  output logic                                 finished_o
);

  exe_if exe ();
  res_if res ();

  //////////////////////////////
  // Three stage pipeline
  //////////////////////////////

  stage_decode u_decode (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .stage_boundary_i (stage_boundary_i),
    .operand1_i       (operand1_i),
    .operand2_i       (operand2_i),
    .operand3_i       (operand3_i),
    .operand4_i       (operand4_i),
    .set_i            (set_i),
    .stage_o          (stage_o),
    .exe              (exe.dec_mp)
  );

  // Product and addend per lane
  lane_execute u_execute (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .exe   (exe.exe_mp),
    .res   (res.exe_mp)
  );

  lane_accumulate u_accumulate (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .res        (res.res_mp),
    .acc_o      (acc_o),
    .finished_o (finished_o)
  );

endmodule

// File: src/stage_if.sv
`timescale 1ns/1ns

//////////////////////////////
// Decode to execute
//////////////////////////////

interface exe_if;
  logic                  valid;  // Step below final boundary
  stage_pkg::op_e        op;
  stage_pkg::lane_data_t op1;
  stage_pkg::lane_data_t op2;
  stage_pkg::lane_data_t op3;
  stage_pkg::lane_data_t op4;
  stage_pkg::lane_data_t set;    // Preload value

  modport dec_mp (output valid, op, op1, op2, op3, op4, set);
  modport exe_mp (input valid, op, op1, op2, op3, op4, set);
endinterface

//////////////////////////////
// Execute to result
//////////////////////////////

interface res_if;
  logic                  valid;
  stage_pkg::op_e        op;
  stage_pkg::lane_data_t prod;   // Saturated op2*op3
  stage_pkg::lane_data_t addend; // Or set value on load

  modport exe_mp (output valid, op, prod, addend);
  modport res_mp (input valid, op, prod, addend);
endinterface

// File: src/stage_pkg.sv
`include "stage_defs.svh"

package stage_pkg;

  typedef logic signed [`STAGE_DATA_W-1:0] data_t;     // Q8.8 word
  typedef logic signed [2*`STAGE_DATA_W-1:0] wide_t;   // Headroom for sums and products
  typedef logic [`STAGE_STEP_W-1:0] step_t;
  typedef logic [3:0] stage_t;                         // 0..7 running, 8 done
  typedef data_t [`STAGE_LANES-1:0] lane_data_t;

  typedef enum logic [2:0] {
    OP_LOAD,
    OP_MAC,
    OP_CORR,
    OP_SUM,
    OP_HOLD
  } op_e;

  localparam int DATA_MAX = 2 ** (`STAGE_DATA_W - 1) - 1;
  localparam int DATA_MIN = -(2 ** (`STAGE_DATA_W - 1));

  // Clamp a wide result back into one data word
  function automatic data_t sat(input wide_t x);
    if (x > DATA_MAX) begin
      return data_t'(DATA_MAX);
    end else if (x < DATA_MIN) begin
      return data_t'(DATA_MIN);
    end
    return x[`STAGE_DATA_W-1:0];
  endfunction

endpackage
